/* logic/dma_arb_pkg.sv */
// Shared engine state type and default array sizes for the DMA read-side bandwidth arbiter
package dma_arb_pkg;

  // ---------------------------------------------------------------------
  // Default sizes, the top level hands these down as module parameters
  // ---------------------------------------------------------------------
  parameter int DEF_NUM_CHANNELS = 4;    // Channels sharing the read side
  parameter int DEF_FRAME_SIZE   = 256;  // Beats handed out per frame
  parameter int DEF_SIZE_WIDTH   = 16;   // Transaction size in beats
  parameter int DEF_PRIO_WIDTH   = 3;    // Priority 1..7, zero means unused

  // ---------------------------------------------------------------------
  // Grant engine states
  // ---------------------------------------------------------------------
  // ARB_IDLE  waits for start with at least one loaded channel
  // ARB_GRANT is the single cycle in which grant_valid is high
  // ARB_WAIT  holds until the requester reports burst_done
  typedef enum logic [1:0] {
    ARB_IDLE  = 2'd0,
    ARB_GRANT = 2'd1,
    ARB_WAIT  = 2'd2
  } arb_state_e;

endpackage

/* logic/channel_table.sv */
// Per-channel register file for the arbiter, loaded by sample pulses and drained by grants
`timescale 1ns/1ps

module channel_table
  import dma_arb_pkg::*;
#(
  parameter int NUM_CHANNELS = DEF_NUM_CHANNELS,
  parameter int FRAME_SIZE   = DEF_FRAME_SIZE,
  parameter int SIZE_WIDTH   = DEF_SIZE_WIDTH,
  parameter int PRIO_WIDTH   = DEF_PRIO_WIDTH,
  // Derived widths
  localparam int CH_W   = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1,
  localparam int BEAT_W = $clog2(FRAME_SIZE + 1)  // Holds FRAME_SIZE itself
) (
  input  logic                    aclk,
  input  logic                    aresetn,
  // Load side, one channel per pulse
  input  logic                    sample_channel,
  input  logic [CH_W-1:0]         channel_number,
  input  logic [PRIO_WIDTH-1:0]   channel_priority,
  input  logic [SIZE_WIDTH-1:0]   transaction_size,
  // Drain side from the grant engine
  input  logic                    consume,
  input  logic [CH_W-1:0]         consume_channel,
  input  logic [BEAT_W-1:0]       consume_beats,
  // Table contents
  output logic [NUM_CHANNELS-1:0] active,
  output logic [PRIO_WIDTH-1:0]   prio      [NUM_CHANNELS],
  output logic [SIZE_WIDTH-1:0]   remaining [NUM_CHANNELS]
);

  // ---------------------------------------------------------------------
  // Active flags, the only control state in the table
  // ---------------------------------------------------------------------
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      active <= '0;
    end else begin
      for (int i = 0; i < NUM_CHANNELS; i++) begin
        if (sample_channel && channel_number == CH_W'(i)) begin
          // Zero priority or zero size never joins the rotation
          active[i] <= (channel_priority != '0) && (transaction_size != '0);
        end else if (consume && consume_channel == CH_W'(i)) begin
          if (remaining[i] == SIZE_WIDTH'(consume_beats)) begin
            active[i] <= 1'b0;  // Used up, leaves the rotation
          end
        end
      end
    end
  end

  // ---------------------------------------------------------------------
  // Priority and remaining beats
  // ---------------------------------------------------------------------
  // Load wins over a consume aimed at the same entry
  always_ff @(posedge aclk) begin
    for (int i = 0; i < NUM_CHANNELS; i++) begin
      if (sample_channel && channel_number == CH_W'(i)) begin
        prio[i]      <= channel_priority;
        remaining[i] <= transaction_size;
      end else if (consume && consume_channel == CH_W'(i)) begin
        remaining[i] <= remaining[i] - SIZE_WIDTH'(consume_beats);  // Burst granted
      end
    end
  end

  // Engine only draws from live channels and never past their remainder
  a_consume_legal: assert property (
    @(posedge aclk) disable iff (!aresetn)
    consume |-> active[consume_channel] &&
                (SIZE_WIDTH'(consume_beats) <= remaining[consume_channel])
  ) else $error("channel_table: illegal consume on channel %0d", consume_channel);

endmodule

/* logic/share_calc.sv */
// Combinational per-channel beats-per-frame, proportional to priority among active channels
`timescale 1ns/1ps

module share_calc
  import dma_arb_pkg::*;
#(
  parameter int NUM_CHANNELS = DEF_NUM_CHANNELS,
  parameter int FRAME_SIZE   = DEF_FRAME_SIZE,
  parameter int PRIO_WIDTH   = DEF_PRIO_WIDTH,
  localparam int BEAT_W = $clog2(FRAME_SIZE + 1),
  localparam int SUM_W  = PRIO_WIDTH + $clog2(NUM_CHANNELS + 1),  // No overflow on the sum
  localparam int PROD_W = BEAT_W + PRIO_WIDTH,                    // FRAME_SIZE * priority
  localparam int DIV_W  = (PROD_W > SUM_W) ? PROD_W : SUM_W
) (
  input  logic [NUM_CHANNELS-1:0] active,
  input  logic [PRIO_WIDTH-1:0]   prio  [NUM_CHANNELS],
  output logic [BEAT_W-1:0]       share [NUM_CHANNELS]
);

  // ---------------------------------------------------------------------
  // Priority sum over the live channels, then one divide per channel
  // ---------------------------------------------------------------------
  always_comb begin
    logic [SUM_W-1:0] prio_sum;
    logic [DIV_W-1:0] scaled;
    logic [DIV_W-1:0] quot;

    prio_sum = '0;
    scaled   = '0;
    quot     = '0;
    for (int i = 0; i < NUM_CHANNELS; i++) begin
      if (active[i]) begin
        prio_sum = prio_sum + SUM_W'(prio[i]);
      end
    end

    for (int i = 0; i < NUM_CHANNELS; i++) begin
      share[i] = '0;                                  // Inactive gets nothing
      if (active[i] && prio_sum != '0) begin
        scaled = DIV_W'(FRAME_SIZE) * DIV_W'(prio[i]);
        quot   = scaled / DIV_W'(prio_sum);          // Rounded down
        if (quot == '0) begin
          share[i] = BEAT_W'(1);                      // Floor of one beat
        end else begin
          share[i] = BEAT_W'(quot);                   // Never above FRAME_SIZE
        end
      end
    end
  end

endmodule

/* logic/rr_pointer.sv */
// Combinational round-robin search for the next active channel after a given origin
`timescale 1ns/1ps

module rr_pointer
  import dma_arb_pkg::*;
#(
  parameter int NUM_CHANNELS = DEF_NUM_CHANNELS,
  localparam int CH_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1
) (
  input  logic [NUM_CHANNELS-1:0] active,
  input  logic [CH_W-1:0]         origin,        // Last granted channel
  output logic [CH_W-1:0]         next_channel,
  output logic                    any_active
);

  assign any_active = |active;

  // ---------------------------------------------------------------------
  // Circular scan origin+1 .. origin, first hit wins
  // ---------------------------------------------------------------------
  // origin itself is checked last, so a lone survivor is granted again
  always_comb begin
    int  idx;
    logic found;

    idx          = 0;
    found        = 1'b0;
    next_channel = origin;  // Don't care when nothing is active
    for (int i = 1; i <= NUM_CHANNELS; i++) begin
      idx = (int'(origin) + i) % NUM_CHANNELS;  // Wrap past the top entry
      if (!found && active[idx]) begin
        next_channel = CH_W'(idx);
        found        = 1'b1;
      end
    end
  end

endmodule

/* logic/grant_engine.sv */
// Arbitration FSM issuing one burst grant at a time, paced by burst completion
`timescale 1ns/1ps

module grant_engine
  import dma_arb_pkg::*;
#(
  parameter int NUM_CHANNELS = DEF_NUM_CHANNELS,
  parameter int FRAME_SIZE   = DEF_FRAME_SIZE,
  parameter int SIZE_WIDTH   = DEF_SIZE_WIDTH,
  localparam int CH_W   = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1,
  localparam int BEAT_W = $clog2(FRAME_SIZE + 1),
  localparam int CMP_W  = (SIZE_WIDTH > BEAT_W) ? SIZE_WIDTH : BEAT_W  // share vs remaining
) (
  input  logic                  aclk,
  input  logic                  aresetn,
  // Control handshake
  input  logic                  start_arbitration,
  input  logic                  burst_done,
  // From the table, share calculator and pointer
  input  logic [BEAT_W-1:0]     share     [NUM_CHANNELS],
  input  logic [SIZE_WIDTH-1:0] remaining [NUM_CHANNELS],
  input  logic [CH_W-1:0]       next_channel,
  input  logic                  any_active,
  output logic [CH_W-1:0]       origin,
  // Table update, same edge as grant_valid
  output logic                  consume,
  output logic [CH_W-1:0]       consume_channel,
  output logic [BEAT_W-1:0]     consume_beats,
  // Grant out
  output logic                  grant_valid,
  output logic [CH_W-1:0]       grant_channel,
  output logic [BEAT_W-1:0]     grant_beats,
  output logic                  re_arbitration,
  output logic                  all_done
);

  arb_state_e state;

  logic [CMP_W-1:0]  share_ext;
  logic [CMP_W-1:0]  rem_ext;
  logic [BEAT_W-1:0] beats_sel;  // min(share, remaining) for next_channel
  logic              last_sel;   // This grant empties the channel
  logic              issue;
  logic              finish;

  // ---------------------------------------------------------------------
  // Grant rule for the channel the pointer found
  // ---------------------------------------------------------------------
  assign share_ext = CMP_W'(share[next_channel]);
  assign rem_ext   = CMP_W'(remaining[next_channel]);
  assign last_sel  = (share_ext >= rem_ext);
  assign beats_sel = last_sel ? BEAT_W'(remaining[next_channel]) : share[next_channel];

  // Start from idle or completion in wait, but only with work left
  assign issue  = any_active &&
                  ((state == ARB_IDLE && start_arbitration) || (state == ARB_WAIT && burst_done));
  assign finish = (state == ARB_WAIT) && burst_done && !any_active;  // Last burst retired

  assign consume         = issue;
  assign consume_channel = next_channel;
  assign consume_beats   = beats_sel;

  // Search from the top index while idle so the lowest live channel goes first
  assign origin = (state == ARB_IDLE) ? CH_W'(NUM_CHANNELS - 1) : grant_channel;

  // ---------------------------------------------------------------------
  // State and pulse outputs
  // ---------------------------------------------------------------------
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      state          <= ARB_IDLE;
      grant_valid    <= 1'b0;
      re_arbitration <= 1'b0;
      all_done       <= 1'b0;
    end else begin
      grant_valid    <= issue;
      re_arbitration <= issue && last_sel;  // Channel drops out with this grant
      all_done       <= finish;
      case (state)
        ARB_IDLE:  if (issue) state <= ARB_GRANT;
        ARB_GRANT: state <= ARB_WAIT;         // grant_valid is a single pulse
        ARB_WAIT: begin
          if (issue) begin
            state <= ARB_GRANT;
          end else if (finish) begin
            state <= ARB_IDLE;
          end
        end
        default:   state <= ARB_IDLE;
      endcase
    end
  end

  // Grant payload, only read while a grant is outstanding
  always_ff @(posedge aclk) begin
    if (issue) begin
      grant_channel <= next_channel;
      grant_beats   <= beats_sel;
    end
  end

  // ---------------------------------------------------------------------
  // Protocol checks
  // ---------------------------------------------------------------------
  a_grant_pulse: assert property (
    @(posedge aclk) disable iff (!aresetn) grant_valid |=> !grant_valid
  ) else $error("grant_engine: grant_valid held longer than one cycle");

  a_done_in_wait: assert property (
    @(posedge aclk) disable iff (!aresetn) burst_done |-> state == ARB_WAIT
  ) else $error("grant_engine: burst_done outside ARB_WAIT, state %s", state.name());

  a_beats_nonzero: assert property (
    @(posedge aclk) disable iff (!aresetn) grant_valid |-> grant_beats != '0
  ) else $error("grant_engine: zero-beat grant on channel %0d", grant_channel);

endmodule

/* logic/dma_bw_arbiter.sv */
// Top level of the DMA read-side bandwidth arbiter, connecting table, share, pointer and FSM
`timescale 1ns/1ps

module dma_bw_arbiter
  import dma_arb_pkg::*;
#(
  parameter int NUM_CHANNELS = DEF_NUM_CHANNELS,
  parameter int FRAME_SIZE   = DEF_FRAME_SIZE,
  parameter int SIZE_WIDTH   = DEF_SIZE_WIDTH,
  parameter int PRIO_WIDTH   = DEF_PRIO_WIDTH,
  localparam int CH_W   = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1,
  localparam int BEAT_W = $clog2(FRAME_SIZE + 1)
) (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  logic                  sample_channel,
  input  logic [CH_W-1:0]       channel_number,
  input  logic [PRIO_WIDTH-1:0] channel_priority,
  input  logic [SIZE_WIDTH-1:0] transaction_size,
  input  logic                  start_arbitration,
  input  logic                  burst_done,
  output logic                  grant_valid,
  output logic [CH_W-1:0]       grant_channel,
  output logic [BEAT_W-1:0]     grant_beats,
  output logic                  re_arbitration,
  output logic                  all_done
);

  // ---------------------------------------------------------------------
  // Internal wiring
  // ---------------------------------------------------------------------
  logic [NUM_CHANNELS-1:0] active;
  logic [PRIO_WIDTH-1:0]   prio      [NUM_CHANNELS];
  logic [SIZE_WIDTH-1:0]   remaining [NUM_CHANNELS];
  logic [BEAT_W-1:0]       share     [NUM_CHANNELS];
  logic [CH_W-1:0]         next_channel;
  logic                    any_active;
  logic [CH_W-1:0]         origin;
  logic                    consume;
  logic [CH_W-1:0]         consume_channel;
  logic [BEAT_W-1:0]       consume_beats;

  channel_table #(
    .NUM_CHANNELS(NUM_CHANNELS), .FRAME_SIZE(FRAME_SIZE),
    .SIZE_WIDTH(SIZE_WIDTH), .PRIO_WIDTH(PRIO_WIDTH)
  ) u_table (
    .aclk(aclk), .aresetn(aresetn),
    .sample_channel(sample_channel), .channel_number(channel_number),
    .channel_priority(channel_priority), .transaction_size(transaction_size),
    .consume(consume), .consume_channel(consume_channel), .consume_beats(consume_beats),
    .active(active), .prio(prio), .remaining(remaining)
  );

  share_calc #(
    .NUM_CHANNELS(NUM_CHANNELS), .FRAME_SIZE(FRAME_SIZE), .PRIO_WIDTH(PRIO_WIDTH)
  ) u_share (
    .active(active), .prio(prio), .share(share)
  );

  rr_pointer #(
    .NUM_CHANNELS(NUM_CHANNELS)
  ) u_pointer (
    .active(active), .origin(origin), .next_channel(next_channel), .any_active(any_active)
  );

  grant_engine #(
    .NUM_CHANNELS(NUM_CHANNELS), .FRAME_SIZE(FRAME_SIZE), .SIZE_WIDTH(SIZE_WIDTH)
  ) u_engine (
    .aclk(aclk), .aresetn(aresetn),
    .start_arbitration(start_arbitration), .burst_done(burst_done),
    .share(share), .remaining(remaining),
    .next_channel(next_channel), .any_active(any_active), .origin(origin),
    .consume(consume), .consume_channel(consume_channel), .consume_beats(consume_beats),
    .grant_valid(grant_valid), .grant_channel(grant_channel), .grant_beats(grant_beats),
    .re_arbitration(re_arbitration), .all_done(all_done)
  );

endmodule

/* sim/tb_dma_bw_arbiter.sv */
// Self-checking testbench for the bandwidth arbiter that runs a scenario table against a grant model
`timescale 1ns/1ps

module tb_dma_bw_arbiter
  import dma_arb_pkg::*;
();

  localparam int NCH      = DEF_NUM_CHANNELS;
  localparam int FRAME    = DEF_FRAME_SIZE;
  localparam int CH_W     = (NCH > 1) ? $clog2(NCH) : 1;
  localparam int BEAT_W   = $clog2(FRAME + 1);
  localparam int NUM_ROWS = 6;

  logic                      aclk;
  logic                      aresetn;
  logic                      sample_channel;
  logic [CH_W-1:0]           channel_number;
  logic [DEF_PRIO_WIDTH-1:0] channel_priority;
  logic [DEF_SIZE_WIDTH-1:0] transaction_size;
  logic                      start_arbitration;
  logic                      burst_done;
  logic                      grant_valid;
  logic [CH_W-1:0]           grant_channel;
  logic [BEAT_W-1:0]         grant_beats;
  logic                      re_arbitration;
  logic                      all_done;

  // ---------------------------------------------------------------------
  // Scenario table where a set mask bit means the channel gets a sample pulse
  // ---------------------------------------------------------------------
  string row_name [NUM_ROWS] = '{"empty_start", "single_channel", "prio_1_2_4",
                                 "small_drains", "skipped_entries", "lone_wrap"};
  int    row_mask [NUM_ROWS] = '{4'b0011, 4'b0100, 4'b0111, 4'b1011, 4'b0111, 4'b1001};
  int    row_prio [NUM_ROWS][NCH] = '{'{0, 3, 0, 0}, '{0, 0, 3, 0}, '{1, 2, 4, 0},
                                      '{1, 2, 0, 2}, '{0, 5, 4, 6}, '{1, 0, 0, 7}};
  int    row_size [NUM_ROWS][NCH] = '{'{10, 0, 0, 0}, '{0, 0, 700, 0}, '{300, 300, 300, 0},
                                      '{400, 20, 0, 600}, '{100, 0, 300, 50}, '{1000, 0, 0, 10}};

  // Reference copy of the channel table
  bit m_act [NCH];
  int m_pri [NCH];
  int m_rem [NCH];

  int seed;
  int cycle_count = 0;
  int cycle_limit = 0;  // Zero until the grant count is known

  dma_bw_arbiter uut (
    .aclk(aclk), .aresetn(aresetn),
    .sample_channel(sample_channel), .channel_number(channel_number),
    .channel_priority(channel_priority), .transaction_size(transaction_size),
    .start_arbitration(start_arbitration), .burst_done(burst_done),
    .grant_valid(grant_valid), .grant_channel(grant_channel), .grant_beats(grant_beats),
    .re_arbitration(re_arbitration), .all_done(all_done)
  );

  always #50 aclk = ~aclk;  // 100 ns period

  // Run limit derived from the predicted grant count
  always @(posedge aclk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("*** TEST FAILED ***");
      $fatal(1, "Simulation stopped by the cycle limit");
    end
  end

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Error: %s expected %0d actual %0d", what, expected, actual);
      $display("*** TEST FAILED ***");
      $fatal(1, "Mismatch in %s", what);
    end
  endtask

  // ---------------------------------------------------------------------
  // Grant model
  // ---------------------------------------------------------------------
  function automatic void load_model(input int r);
    for (int c = 0; c < NCH; c++) begin
      m_pri[c] = row_prio[r][c];
      m_rem[c] = row_size[r][c];
      m_act[c] = ((row_mask[r] >> c) & 1) && m_pri[c] != 0 && m_rem[c] != 0;
    end
  endfunction

  function automatic bit model_any_active();
    bit any;
    any = 1'b0;
    for (int c = 0; c < NCH; c++) begin
      any |= m_act[c];
    end
    return any;
  endfunction

  // Predicts the next channel after origin and its share capped by what it still needs
  function automatic void predict_grant(input int origin, output int ch, output int beats,
                                        output bit last);
    int sum;
    int share;
    int idx;
    sum = 0;
    ch  = -1;
    for (int c = 0; c < NCH; c++) begin
      if (m_act[c]) begin
        sum += m_pri[c];
      end
    end
    for (int i = 1; i <= NCH; i++) begin
      idx = (origin + i) % NCH;
      if (ch < 0 && m_act[idx]) ch = idx;  // First live channel wins
    end
    share = FRAME * m_pri[ch] / sum;
    if (share == 0) share = 1;
    beats = (share < m_rem[ch]) ? share : m_rem[ch];
    last  = (beats == m_rem[ch]);
    m_rem[ch] -= beats;
    if (last) m_act[ch] = 1'b0;  // Leaves the rotation
  endfunction

  function automatic int count_grants(input int r);
    int n;
    int ch;
    int beats;
    bit last;
    n  = 0;
    ch = NCH - 1;
    load_model(r);
    while (model_any_active()) begin
      predict_grant(ch, ch, beats, last);
      n++;
    end
    return n;
  endfunction

  // ---------------------------------------------------------------------
  // Stimulus
  // ---------------------------------------------------------------------
  task automatic reset_dut(input string name);
    @(posedge aclk);
    aresetn           <= 1'b0;
    sample_channel    <= 1'b0;
    start_arbitration <= 1'b0;
    burst_done        <= 1'b0;
    repeat (8) @(posedge aclk);
    aresetn <= 1'b1;
    repeat (2) begin
      @(negedge aclk);  // Outputs quiet with no stimulus
      check_value({name, ": grant_valid after reset"}, 0, grant_valid);
      check_value({name, ": re_arbitration after reset"}, 0, re_arbitration);
      check_value({name, ": all_done after reset"}, 0, all_done);
    end
  endtask

  task automatic sample_channels(input int r);
    for (int c = 0; c < NCH; c++) begin
      if ((row_mask[r] >> c) & 1) begin
        @(posedge aclk);
        sample_channel   <= 1'b1;
        channel_number   <= CH_W'(c);
        channel_priority <= DEF_PRIO_WIDTH'(row_prio[r][c]);
        transaction_size <= DEF_SIZE_WIDTH'(row_size[r][c]);
      end
    end
    @(posedge aclk);
    sample_channel <= 1'b0;
  endtask

  // Withholds burst_done for gap cycles before pulsing it and returns where the answer is visible
  task automatic answer_grant(input string name, input int gap);
    repeat (gap) begin
      @(posedge aclk);
      @(negedge aclk);
      check_value({name, ": grant_valid while waiting"}, 0, grant_valid);
    end
    @(posedge aclk);
    burst_done <= 1'b1;
    @(negedge aclk);
    check_value({name, ": grant_valid before burst_done"}, 0, grant_valid);
    @(posedge aclk);
    burst_done <= 1'b0;
    @(negedge aclk);
  endtask

  task automatic run_row(input int r);
    int    origin;
    int    exp_ch;
    int    exp_beats;
    int    gap;
    bit    exp_last;
    string name;
    name = row_name[r];
    reset_dut(name);
    load_model(r);
    sample_channels(r);
    @(posedge aclk);
    start_arbitration <= 1'b1;
    @(posedge aclk);
    start_arbitration <= 1'b0;
    @(negedge aclk);
    if (!model_any_active()) begin
      repeat (4) begin  // Start is ignored with nothing loaded
        check_value({name, ": grant_valid without work"}, 0, grant_valid);
        check_value({name, ": all_done without work"}, 0, all_done);
        @(negedge aclk);
      end
    end else begin
      origin = NCH - 1;
      while (model_any_active()) begin
        predict_grant(origin, exp_ch, exp_beats, exp_last);
        origin = exp_ch;
        check_value({name, ": grant_valid"}, 1, grant_valid);
        check_value({name, ": grant_channel"}, exp_ch, grant_channel);
        check_value({name, ": grant_beats"}, exp_beats, grant_beats);
        check_value({name, ": re_arbitration"}, exp_last, re_arbitration);
        check_value({name, ": all_done early"}, 0, all_done);
        gap = $unsigned($random(seed)) % 4;
        answer_grant(name, gap);
      end
      check_value({name, ": all_done"}, 1, all_done);
      check_value({name, ": grant_valid after last"}, 0, grant_valid);
      @(negedge aclk);
      check_value({name, ": all_done single pulse"}, 0, all_done);
    end
  endtask

  initial begin
    int total;
    aclk              = 1'b0;
    aresetn           = 1'b0;
    sample_channel    = 1'b0;
    channel_number    = '0;
    channel_priority  = '0;
    transaction_size  = '0;
    start_arbitration = 1'b0;
    burst_done        = 1'b0;
    seed              = 32'ha5ad_1d3a;
    total             = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      total += 8 + count_grants(r) * 6;
    end
    cycle_limit = 4 * total;
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* all.f */
logic/dma_arb_pkg.sv
logic/channel_table.sv
logic/share_calc.sv
logic/rr_pointer.sv
logic/grant_engine.sv
logic/dma_bw_arbiter.sv
sim/tb_dma_bw_arbiter.sv
